/* arcade_pkg.sv */
package arcade_pkg;

	localparam int ROM_ADDR_W = 15; // 32 KiB byte store

	// PS/2 set 2 scancodes
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_COIN   = 8'h76; // esc
	localparam logic [7:0] SC_START1 = 8'h05; // f1
	localparam logic [7:0] SC_START2 = 8'h06; // f2
	localparam logic [7:0] SC_FIRE   = 8'h29; // space

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	localparam int ST_RESET      = 0;
	localparam int ST_SCAN_LO    = 3; // scanline option, 2 bits
	localparam int ST_SCAN_HI    = 4;
	localparam int ST_MENU_RESET = 6;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} ctrl_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hblank;
		logic       vblank;
		logic       hs;
		logic       vs;
	} rgb_in_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} rgb_out_t;

endpackage

/* input_mapper.sv */
`timescale 1ns/100ps

module input_mapper import arcade_pkg::*; (
	input  logic       clock_48,
	input  logic       rst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	output ctrl_t      controls
);

	logic       strobe_d;
	logic       key_event;
	ctrl_t      keys; // held keyboard buttons
	logic [7:0] joy_any;

	assign key_event = key_strobe != strobe_d; // toggles in either direction
	assign joy_any   = joystick_0 | joystick_1;

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			strobe_d <= 1'b0;
			keys     <= '0;
		end else begin
			strobe_d <= key_strobe;
			if (key_event) begin
				case (key_code)
					SC_UP:     keys.up     <= key_pressed;
					SC_DOWN:   keys.down   <= key_pressed;
					SC_LEFT:   keys.left   <= key_pressed;
					SC_RIGHT:  keys.right  <= key_pressed;
					SC_COIN:   keys.coin   <= key_pressed;
					SC_START1: keys.start1 <= key_pressed;
					SC_START2: keys.start2 <= key_pressed;
					SC_FIRE:   keys.fire   <= key_pressed;
					default: ; // other keys ignored
				endcase
			end
		end
	end

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			controls <= '0;
		end else begin
			controls.coin   <= keys.coin; // keyboard only
			controls.start1 <= keys.start1;
			controls.start2 <= keys.start2;
			controls.up     <= keys.up | joy_any[JOY_UP];
			controls.down   <= keys.down | joy_any[JOY_DOWN];
			controls.left   <= keys.left | joy_any[JOY_LEFT];
			controls.right  <= keys.right | joy_any[JOY_RIGHT];
			controls.fire   <= keys.fire | joy_any[JOY_FIRE];
		end
	end

	// user_io must present a settled code with every strobe toggle
	a_key_code_known: assert property (@(posedge clock_48) disable iff (!rst_n)
		key_event |-> !$isunknown(key_code));

endmodule

/* rom_loader.sv */
`timescale 1ns/100ps

module rom_loader import arcade_pkg::*; (
	input  logic                  clock_48,
	input  logic                  rst_n,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [24:0]           ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic [ROM_ADDR_W-1:0] rom_addr,
	input  logic                  rom_rd,
	output logic [7:0]            rom_data,
	input  logic [31:0]           status,
	input  logic [1:0]            buttons,
	output logic                  core_reset,
	output logic                  rom_loaded
);

	logic [7:0] rom_mem [0:(1 << ROM_ADDR_W) - 1];
	logic       download_q; // registered download level
	logic       download_d; // one cycle older
	logic       download_end;
	logic       rom_we;
	logic       rom_re;

	assign rom_we       = ioctl_download & ioctl_wr;
	assign rom_re       = ~ioctl_download & rom_rd; // core locked out while loading
	assign download_end = download_d & ~download_q;

	always_ff @(posedge clock_48) begin
		if (rom_we) begin
			rom_mem[ioctl_addr[ROM_ADDR_W-1:0]] <= ioctl_dout;
		end
	end

	// read data holds until the next accepted read
	always_ff @(posedge clock_48) begin
		if (rom_re) begin
			rom_data <= rom_mem[rom_addr];
		end
	end

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_q <= ioctl_download;
			download_d <= download_q;
			if (download_end) begin
				rom_loaded <= 1'b1; // sticky until rst_n
			end
			core_reset <= status[ST_RESET] | status[ST_MENU_RESET] |
				buttons[1] | ~rom_loaded;
		end
	end

	// data_io only writes inside a download window
	a_wr_in_download: assert property (@(posedge clock_48) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download);

	// core stays in reset until the ROM image is complete
	a_reset_until_loaded: assert property (@(posedge clock_48) disable iff (!rst_n)
		!rom_loaded |-> core_reset);

endmodule

/* video_out.sv */
`timescale 1ns/100ps

module video_out import arcade_pkg::*; (
	input  logic       clock_48,
	input  logic       rst_n,
	input  rgb_in_t    video_in,
	input  logic [1:0] scanlines,
	output rgb_out_t   video_o
);

	logic       blank;
	logic [2:0] b3;
	logic [5:0] r_wide;
	logic [5:0] g_wide;
	logic [5:0] b_wide;
	logic       line_odd;
	logic       new_line;
	logic       dim_line;

	// scanline attenuation, 1 = -25%, 2 = -50%, 3 = -75%
	function automatic logic [5:0] dim(input logic [5:0] v, input logic [1:0] sl);
		logic [5:0] res;
		case (sl)
			2'd1:    res = v - {2'b00, v[5:2]};
			2'd2:    res = {1'b0, v[5:1]};
			2'd3:    res = {2'b00, v[5:2]};
			default: res = v;
		endcase
		return res;
	endfunction

	assign blank = video_in.hblank | video_in.vblank;
	assign b3    = {video_in.b, video_in.b[0]}; // 2 to 3 bits

	assign r_wide = blank ? 6'd0 : {video_in.r, video_in.r};
	assign g_wide = blank ? 6'd0 : {video_in.g, video_in.g};
	assign b_wide = blank ? 6'd0 : {b3, b3};

	// output hs is the input hs of the previous cycle
	assign new_line = video_in.hs & ~video_o.hs;
	assign dim_line = line_odd ^ new_line; // parity of the line now arriving

	always_ff @(posedge clock_48) begin
		if (!rst_n) begin
			line_odd <= 1'b0;
			video_o  <= '0;
		end else begin
			if (new_line) begin
				line_odd <= ~line_odd;
			end
			video_o.r  <= dim_line ? dim(r_wide, scanlines) : r_wide;
			video_o.g  <= dim_line ? dim(g_wide, scanlines) : g_wide;
			video_o.b  <= dim_line ? dim(b_wide, scanlines) : b_wide;
			video_o.hs <= video_in.hs; // same latency as colours
			video_o.vs <= video_in.vs;
		end
	end

endmodule

/* arcade_glue_top.sv */
`timescale 1ns/100ps

module arcade_glue_top import arcade_pkg::*; (
	input  logic                  clock_48,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  logic [7:0]            key_code,
	input  logic [7:0]            joystick_0,
	input  logic [7:0]            joystick_1,
	input  logic [31:0]           status,
	input  logic [1:0]            buttons,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [24:0]           ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic [ROM_ADDR_W-1:0] rom_addr,
	input  logic                  rom_rd,
	input  rgb_in_t               video_in,
	output ctrl_t                 controls,
	output logic [7:0]            rom_data,
	output logic                  core_reset,
	output logic                  rom_loaded,
	output rgb_out_t              video_o
);

	input_mapper u_input_mapper (
		.clock_48    (clock_48),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.controls    (controls)
	);

	rom_loader u_rom_loader (
		.clock_48       (clock_48),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_addr       (rom_addr),
		.rom_rd         (rom_rd),
		.rom_data       (rom_data),
		.status         (status),
		.buttons        (buttons),
		.core_reset     (core_reset),
		.rom_loaded     (rom_loaded)
	);

	video_out u_video_out (
		.clock_48  (clock_48),
		.rst_n     (rst_n),
		.video_in  (video_in),
		.scanlines (status[ST_SCAN_HI:ST_SCAN_LO]), // menu scanline option
		.video_o   (video_o)
	);

endmodule

/* tb_arcade_glue.sv */
`timescale 1ns/100ps

module tb_arcade_glue import arcade_pkg::*; ();

	logic                  clock_48;
	logic                  rst_n;
	logic                  key_strobe;
	logic                  key_pressed;
	logic [7:0]            key_code;
	logic [7:0]            joystick_0;
	logic [7:0]            joystick_1;
	logic [31:0]           status;
	logic [1:0]            buttons;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	logic [24:0]           ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic                  rom_rd;
	rgb_in_t               video_in;
	ctrl_t                 controls;
	logic [7:0]            rom_data;
	logic                  core_reset;
	logic                  rom_loaded;
	rgb_out_t              video_o;

	integer                seed;
	int                    errors;
	int                    timeouts;
	int                    checks;
	logic [7:0]            model_mem [0:(1 << ROM_ADDR_W) - 1]; // expected ROM contents
	logic [ROM_ADDR_W-1:0] addr_q [$];
	logic                  line_odd_m; // expected line parity
	logic                  hs_prev_m;
	rgb_out_t              video_prev_m; // last expected video output

	arcade_glue_top uut (.*);

	always #2 clock_48 = ~clock_48;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	function automatic ctrl_t key_ctrl(input logic [7:0] code);
		ctrl_t c;
		c = '0;
		case (code)
			SC_UP:     c.up = 1'b1;
			SC_DOWN:   c.down = 1'b1;
			SC_LEFT:   c.left = 1'b1;
			SC_RIGHT:  c.right = 1'b1;
			SC_COIN:   c.coin = 1'b1;
			SC_START1: c.start1 = 1'b1;
			SC_START2: c.start2 = 1'b1;
			SC_FIRE:   c.fire = 1'b1;
			default: ;
		endcase
		return c;
	endfunction

	function automatic ctrl_t joy_ctrl(input int bit_pos);
		ctrl_t c;
		c = '0;
		case (bit_pos)
			JOY_RIGHT: c.right = 1'b1;
			JOY_LEFT:  c.left = 1'b1;
			JOY_DOWN:  c.down = 1'b1;
			JOY_UP:    c.up = 1'b1;
			default:   c.fire = 1'b1;
		endcase
		return c;
	endfunction

	function automatic logic [5:0] dimmed(input logic [5:0] v, input logic [1:0] sl,
		input logic odd);
		if (!odd)
			return v;
		case (sl)
			2'd1:    return v - (v >> 2);
			2'd2:    return v >> 1;
			2'd3:    return v >> 2;
			default: return v;
		endcase
	endfunction

	task automatic press_key(input logic [7:0] code, input logic pressed, input ctrl_t expected);
		@(posedge clock_48);
		key_strobe  <= ~key_strobe;
		key_code    <= code;
		key_pressed <= pressed;
		repeat (2) @(posedge clock_48);
		@(negedge clock_48);
		check_value("controls", 32'(expected), 32'(controls));
	endtask

	task automatic set_joysticks(input logic [7:0] j0, input logic [7:0] j1, input ctrl_t expected);
		@(posedge clock_48);
		joystick_0 <= j0;
		joystick_1 <= j1;
		@(posedge clock_48);
		@(negedge clock_48);
		check_value("controls", 32'(expected), 32'(controls));
	endtask

	task automatic read_rom(input logic [ROM_ADDR_W-1:0] a);
		@(posedge clock_48);
		rom_rd   <= 1'b1;
		rom_addr <= a;
		@(posedge clock_48);
		rom_rd <= 1'b0; // data must hold after rd drops
		@(negedge clock_48);
		check_value("rom_data", 32'(model_mem[a]), 32'(rom_data));
	endtask

	task automatic wait_loaded();
		int n;
		n = 0;
		while (rom_loaded !== 1'b1 && n < 20) begin
			@(negedge clock_48);
			n++;
		end
		if (rom_loaded !== 1'b1) begin
			timeouts++;
			$display("timeout: rom_loaded did not rise after the download ended");
		end
		n = 0;
		while (core_reset !== 1'b0 && n < 20) begin
			@(negedge clock_48);
			n++;
		end
		if (core_reset !== 1'b0) begin
			timeouts++;
			$display("timeout: core_reset stayed high after the ROM was loaded");
		end
	endtask

	task automatic drive_reset_source(input int src, input logic level);
		@(posedge clock_48);
		case (src)
			0:       status[ST_RESET] <= level;
			1:       status[ST_MENU_RESET] <= level;
			default: buttons[1] <= level;
		endcase
		@(posedge clock_48);
		@(negedge clock_48);
		check_value("core_reset", 32'(level), 32'(core_reset));
	endtask

	task automatic video_cycle(input rgb_in_t pix, input logic [1:0] sl);
		logic     blank;
		logic [2:0] b3;
		rgb_out_t exp;
		if (pix.hs && !hs_prev_m)
			line_odd_m = !line_odd_m; // new line starts with this pixel
		hs_prev_m = pix.hs;
		blank  = pix.hblank | pix.vblank;
		b3     = {pix.b, pix.b[0]};
		exp.r  = blank ? 6'd0 : dimmed({pix.r, pix.r}, sl, line_odd_m);
		exp.g  = blank ? 6'd0 : dimmed({pix.g, pix.g}, sl, line_odd_m);
		exp.b  = blank ? 6'd0 : dimmed({b3, b3}, sl, line_odd_m);
		exp.hs = pix.hs;
		exp.vs = pix.vs;
		@(posedge clock_48);
		video_in <= pix;
		status[ST_SCAN_HI:ST_SCAN_LO] <= sl;
		@(negedge clock_48);
		check_value("video_o (previous pixel)", 32'(video_prev_m), 32'(video_o));
		@(posedge clock_48);
		@(negedge clock_48);
		check_value("video_o.r", 32'(exp.r), 32'(video_o.r));
		check_value("video_o.g", 32'(exp.g), 32'(video_o.g));
		check_value("video_o.b", 32'(exp.b), 32'(video_o.b));
		check_value("video_o.hs/vs", 32'({exp.hs, exp.vs}), 32'({video_o.hs, video_o.vs}));
		video_prev_m = exp;
	endtask

	task automatic test_keyboard();
		logic [7:0] codes [8];
		codes = '{SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT, SC_COIN, SC_START1, SC_START2, SC_FIRE};
		for (int i = 0; i < 8; i++) begin
			press_key(codes[i], 1'b1, key_ctrl(codes[i]));
			press_key(codes[i], 1'b0, '0);
		end
		press_key(8'h1C, 1'b1, '0); // unmapped key
		press_key(8'h1C, 1'b0, '0);
	endtask

	task automatic test_joystick();
		for (int b = 0; b < 5; b++) begin
			set_joysticks(8'd1 << b, 8'd0, joy_ctrl(b));
			set_joysticks(8'd0, 8'd0, '0);
			set_joysticks(8'd0, 8'd1 << b, joy_ctrl(b));
			set_joysticks(8'd0, 8'd0, '0);
		end
	endtask

	task automatic test_download();
		logic [31:0]           rnd;
		logic [ROM_ADDR_W-1:0] a;
		logic [7:0]            held;
		check_value("core_reset", 32'd1, 32'(core_reset));
		check_value("rom_loaded", 32'd0, 32'(rom_loaded));
		@(posedge clock_48);
		ioctl_download <= 1'b1;
		@(negedge clock_48);
		held = rom_data;
		for (int i = 0; i < 64; i++) begin
			@(posedge clock_48);
			rnd = $random(seed);
			a   = rnd[ROM_ADDR_W-1:0];
			ioctl_addr <= rnd[24:0]; // upper bits beyond the store are dropped
			rnd = $random(seed);
			ioctl_dout <= rnd[7:0];
			ioctl_wr   <= 1'b1;
			model_mem[a] = rnd[7:0];
			addr_q.push_back(a);
			rom_rd   <= 1'b1; // core read during download
			rom_addr <= addr_q[0];
		end
		@(negedge clock_48);
		check_value("rom_data", 32'(held), 32'(rom_data));
		@(posedge clock_48);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		rom_rd         <= 1'b0;
		wait_loaded();
		foreach (addr_q[i])
			read_rom(addr_q[i]);
	endtask

	task automatic test_reset_sources();
		for (int src = 0; src < 3; src++) begin
			drive_reset_source(src, 1'b1);
			drive_reset_source(src, 1'b0);
		end
	endtask

	task automatic test_video();
		logic [31:0] rnd;
		rgb_in_t     pix;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			pix = rnd[11:0];
			{pix.hblank, pix.vblank, pix.hs, pix.vs} = 4'b0000;
			video_cycle(pix, 2'd0);
		end
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			pix = rnd[11:0];
			pix.hblank = (i % 2) == 0;
			pix.vblank = (i % 2) == 1;
			pix.hs     = 1'b0;
			video_cycle(pix, rnd[13:12]);
		end
		for (int i = 0; i < 16; i++) begin // random syncs
			rnd = $random(seed);
			pix = rnd[11:0];
			{pix.hblank, pix.vblank} = 2'b00;
			video_cycle(pix, 2'd0);
		end
		if (line_odd_m) begin // back to an even line
			video_cycle(12'h000, 2'd0);
			video_cycle(12'h002, 2'd0);
		end
		for (int sl = 1; sl < 4; sl++) begin
			for (int step = 0; step < 5; step++) begin
				rnd = $random(seed);
				pix = rnd[11:0];
				{pix.hblank, pix.vblank, pix.vs} = 3'b000;
				pix.hs = (step % 2) == 1; // two rising edges, odd then even
				video_cycle(pix, 2'(sl));
			end
		end
	endtask

	initial begin
		seed           = 18;
		errors         = 0;
		timeouts       = 0;
		checks         = 0;
		line_odd_m     = 1'b0;
		hs_prev_m      = 1'b0;
		video_prev_m   = '0;
		clock_48       = 1'b0;
		rst_n          = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = 8'd0;
		joystick_0     = 8'd0;
		joystick_1     = 8'd0;
		status         = 32'd0;
		buttons        = 2'd0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = 25'd0;
		ioctl_dout     = 8'd0;
		rom_addr       = '0;
		rom_rd         = 1'b0;
		video_in       = '0;
		repeat (4) @(posedge clock_48);
		rst_n <= 1'b1;
		@(negedge clock_48);
		check_value("controls", 32'd0, 32'(controls));
		check_value("video_o", 32'd0, 32'(video_o));
		test_keyboard();
		test_joystick();
		test_download();
		test_reset_sources();
		test_video();
		repeat (2) @(posedge clock_48);
		$display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* sources.f */
arcade_pkg.sv
input_mapper.sv
rom_loader.sv
video_out.sv
arcade_glue_top.sv
tb_arcade_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the testbench, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
	--top-module tb_arcade_glue -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if grep -qxF '** PASS **' <<< "$output"; then
	exit 0
else
	exit 1
fi
